// File: include/datapath_macros.svh
// datapath sizing macros
`ifndef DATAPATH_MACROS_SVH
`define DATAPATH_MACROS_SVH

// data and address width
`define DP_WORD_W 32

// architectural register count
`define DP_REG_N 32

// first fetch address after reset
`define DP_RESET_PC 32'h0000_0000

`endif

// File: hdl/datapath_pkg.sv
// datapath shared types
`include "datapath_macros.svh"

package datapath_pkg;

    typedef logic [`DP_WORD_W-1:0] word_t;
    typedef logic [$clog2(`DP_REG_N)-1:0] reg_sel_t;

    // rv32i subset plus the all-ones halt word
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_IMM    = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_HALT   = 7'b1111111
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_t;

    typedef enum logic [1:0] {
        FU_ALU,
        FU_LS,
        FU_BR,
        FU_NONE
    } fu_sel_t;

    // fetch to scoreboard
    typedef struct packed {
        logic  valid;
        word_t instr;
        word_t pc;
    } fetch_t;

    // scoreboard to execute
    typedef struct packed {
        logic     valid;
        fu_sel_t  fu_sel;
        alu_op_t  alu_op;
        logic     use_imm;
        word_t    rdat1;
        word_t    rdat2;
        word_t    imm;
        word_t    pc;
        reg_sel_t rd;
        logic     bne;
        logic     store;
        logic     jal;
        logic     halt;
    } issue_t;

    // execute to writeback
    typedef struct packed {
        logic     done;
        word_t    result;
        reg_sel_t rd;
        logic     wen;
        logic     halt;
    } execute_t;

    typedef struct packed {
        logic  miss;
        word_t pc;
    } redirect_t;

    typedef struct packed {
        logic     wen;
        reg_sel_t sel;
        word_t    data;
    } wb_t;

endpackage

// File: hdl/fetch_stage.sv
// instruction fetch
`include "datapath_macros.svh"

module fetch_stage (
    input  logic                    CLK,
    input  logic                    nrst,
    input  logic                    ihit,
    input  datapath_pkg::word_t     imemload,
    input  logic                    freeze,
    input  datapath_pkg::redirect_t redirect,
    input  logic                    halted_fetch,
    output logic                    imemREN,
    output datapath_pkg::word_t     imemaddr,
    output datapath_pkg::fetch_t    fetch_out
);
    datapath_pkg::word_t pc;
    logic stopped;
    logic take;

    // keep requesting until a halt word is accepted
    assign imemREN  = !stopped && !halted_fetch;
    assign imemaddr = pc;

    // a hit while frozen is dropped and the same pc asked for again
    assign take = imemREN && ihit && !freeze;

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            pc        <= `DP_RESET_PC;
            stopped   <= 1'b0;
            fetch_out <= '0;
        end else if (redirect.miss) begin
            // not-taken guess was wrong, restart at the target
            pc              <= redirect.pc;
            stopped         <= 1'b0;
            fetch_out.valid <= 1'b0;
        end else if (!freeze) begin
            fetch_out.valid <= take;
            fetch_out.instr <= imemload;
            fetch_out.pc    <= pc;
            if (take) begin
                pc      <= pc + datapath_pkg::word_t'(4);
                stopped <= (imemload == '1);
            end
        end
    end

endmodule

// File: hdl/scoreboard.sv
// decode, hazard tracking and issue
`include "datapath_macros.svh"

module scoreboard (
    input  logic                    CLK,
    input  logic                    nrst,
    input  datapath_pkg::fetch_t    fetch_in,
    input  datapath_pkg::redirect_t redirect,
    input  logic                    busy,
    input  datapath_pkg::wb_t       wb_in,
    input  datapath_pkg::word_t     rdat1,
    input  datapath_pkg::word_t     rdat2,
    output datapath_pkg::reg_sel_t  rsel1,
    output datapath_pkg::reg_sel_t  rsel2,
    output logic                    freeze,
    output datapath_pkg::issue_t    issue_out
);
    typedef enum logic {SB_IDLE, SB_WAIT_BRANCH} sb_state_t;

    sb_state_t state;
    logic [`DP_REG_N-1:0] pending;
    datapath_pkg::word_t instr;
    datapath_pkg::opcode_t opcode;
    datapath_pkg::reg_sel_t rd;
    datapath_pkg::issue_t dec;
    logic use1, use2, writes_rd, is_ctrl;
    logic hazard, blocked, issue_now;

    function automatic datapath_pkg::alu_op_t alu_decode(input logic [2:0] f3, input logic alt);
        datapath_pkg::alu_op_t op;
        case (f3)
            3'b000:  op = alt ? datapath_pkg::ALU_SUB : datapath_pkg::ALU_ADD;
            3'b010:  op = datapath_pkg::ALU_SLT;
            3'b100:  op = datapath_pkg::ALU_XOR;
            3'b110:  op = datapath_pkg::ALU_OR;
            3'b111:  op = datapath_pkg::ALU_AND;
            default: op = datapath_pkg::ALU_ADD;
        endcase
        return op;
    endfunction

    assign instr  = fetch_in.instr;
    assign opcode = datapath_pkg::opcode_t'(instr[6:0]);
    assign rsel1  = instr[19:15];
    assign rsel2  = instr[24:20];
    assign rd     = instr[11:7];

    always_comb begin
        dec       = '0;
        use1      = 1'b0;
        use2      = 1'b0;
        writes_rd = 1'b0;
        dec.fu_sel = datapath_pkg::FU_NONE;
        dec.alu_op = datapath_pkg::ALU_ADD;
        dec.rdat1  = rdat1;
        dec.rdat2  = rdat2;
        dec.pc     = fetch_in.pc;
        dec.rd     = rd;
        dec.bne    = instr[12];
        case (opcode)
            datapath_pkg::OPC_OP: begin
                dec.fu_sel = datapath_pkg::FU_ALU;
                dec.alu_op = alu_decode(instr[14:12], instr[30]);
                {use1, use2, writes_rd} = 3'b111;
            end
            datapath_pkg::OPC_IMM: begin
                dec.fu_sel  = datapath_pkg::FU_ALU;
                dec.alu_op  = alu_decode(instr[14:12], 1'b0);
                dec.use_imm = 1'b1;
                dec.imm     = {{20{instr[31]}}, instr[31:20]};
                {use1, writes_rd} = 2'b11;
            end
            datapath_pkg::OPC_LOAD: begin
                dec.fu_sel = datapath_pkg::FU_LS;
                dec.imm    = {{20{instr[31]}}, instr[31:20]};
                {use1, writes_rd} = 2'b11;
            end
            datapath_pkg::OPC_STORE: begin
                dec.fu_sel = datapath_pkg::FU_LS;
                dec.store  = 1'b1;
                dec.imm    = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                {use1, use2} = 2'b11;
            end
            datapath_pkg::OPC_BRANCH: begin
                dec.fu_sel = datapath_pkg::FU_BR;
                dec.imm    = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                              instr[11:8], 1'b0};
                {use1, use2} = 2'b11;
            end
            datapath_pkg::OPC_JAL: begin
                dec.fu_sel = datapath_pkg::FU_BR;
                dec.jal    = 1'b1;
                dec.imm    = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                              instr[30:21], 1'b0};
                writes_rd  = 1'b1;
            end
            datapath_pkg::OPC_HALT: dec.halt = 1'b1;
            default: ;
        endcase
        // x0 never goes pending
        writes_rd = writes_rd && (rd != '0);
    end

    assign is_ctrl = (opcode == datapath_pkg::OPC_BRANCH) || (opcode == datapath_pkg::OPC_JAL);

    // waw included, completions clear bits in order
    assign hazard = (use1 && pending[rsel1]) || (use2 && pending[rsel2]) ||
                    (writes_rd && pending[rd]);

    // branch still sitting in the issue register, not yet resolved
    assign blocked   = (state == SB_WAIT_BRANCH) && issue_out.valid;
    assign issue_now = fetch_in.valid && !busy && !blocked && !hazard && !redirect.miss;
    assign freeze    = fetch_in.valid && !issue_now && !redirect.miss;

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            state     <= SB_IDLE;
            pending   <= '0;
            issue_out <= '0;
        end else begin
            issue_out       <= dec;
            issue_out.valid <= issue_now;
            if (wb_in.wen) begin
                pending[wb_in.sel] <= 1'b0;
            end
            if (issue_now && writes_rd) begin
                pending[rd] <= 1'b1;
            end
            case (state)
                SB_IDLE: begin
                    if (issue_now && is_ctrl) begin
                        state <= SB_WAIT_BRANCH;
                    end
                end
                SB_WAIT_BRANCH: begin
                    if (!issue_out.valid && !(issue_now && is_ctrl)) begin
                        state <= SB_IDLE;
                    end
                end
                default: state <= SB_IDLE;
            endcase
        end
    end

endmodule

// File: hdl/regfile.sv
// integer register file
`include "datapath_macros.svh"

module regfile (
    input  logic                   CLK,
    input  logic                   nrst,
    input  datapath_pkg::wb_t      wb_in,
    input  datapath_pkg::reg_sel_t rsel1,
    input  datapath_pkg::reg_sel_t rsel2,
    output datapath_pkg::word_t    rdat1,
    output datapath_pkg::word_t    rdat2
);
    datapath_pkg::word_t regs [`DP_REG_N];

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < `DP_REG_N; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_in.wen && (wb_in.sel != '0)) begin
            regs[wb_in.sel] <= wb_in.data;
        end
    end

    // x0 hardwired
    assign rdat1 = (rsel1 == '0) ? '0 : regs[rsel1];
    assign rdat2 = (rsel2 == '0) ? '0 : regs[rsel2];

endmodule

// File: hdl/execute.sv
// alu, branch unit and scalar load/store
module execute (
    input  logic                    CLK,
    input  logic                    nrst,
    input  datapath_pkg::issue_t    issue_in,
    input  logic                    dhit,
    input  datapath_pkg::word_t     dmemload,
    output logic                    dmemREN,
    output logic                    dmemWEN,
    output datapath_pkg::word_t     dmemstore,
    output datapath_pkg::word_t     dmemaddr,
    output logic                    busy,
    output datapath_pkg::execute_t  ex_out,
    output datapath_pkg::redirect_t redirect
);
    typedef enum logic {LS_IDLE, LS_WAIT_HIT} ls_state_t;

    ls_state_t ls_state;
    datapath_pkg::word_t operand_b, alu_result;
    datapath_pkg::word_t ls_addr, ls_data;
    datapath_pkg::reg_sel_t ls_rd;
    datapath_pkg::execute_t ex_next;
    logic ls_store, taken, is_ls;

    assign operand_b = issue_in.use_imm ? issue_in.imm : issue_in.rdat2;

    always_comb begin
        case (issue_in.alu_op)
            datapath_pkg::ALU_SUB: alu_result = issue_in.rdat1 - operand_b;
            datapath_pkg::ALU_AND: alu_result = issue_in.rdat1 & operand_b;
            datapath_pkg::ALU_OR:  alu_result = issue_in.rdat1 | operand_b;
            datapath_pkg::ALU_XOR: alu_result = issue_in.rdat1 ^ operand_b;
            datapath_pkg::ALU_SLT: begin
                alu_result = datapath_pkg::word_t'($signed(issue_in.rdat1) < $signed(operand_b));
            end
            default: alu_result = issue_in.rdat1 + operand_b;
        endcase
    end

    // beq vs bne from funct3 bit 0
    assign taken = issue_in.bne ? (issue_in.rdat1 != issue_in.rdat2)
                                : (issue_in.rdat1 == issue_in.rdat2);

    assign is_ls = issue_in.valid && (issue_in.fu_sel == datapath_pkg::FU_LS);
    assign busy  = (ls_state == LS_WAIT_HIT) || is_ls;

    // request levels held until dhit
    assign dmemREN   = (ls_state == LS_WAIT_HIT) && !ls_store;
    assign dmemWEN   = (ls_state == LS_WAIT_HIT) && ls_store;
    assign dmemstore = ls_data;
    assign dmemaddr  = ls_addr;

    always_comb begin
        ex_next = '0;
        if ((ls_state == LS_WAIT_HIT) && dhit) begin
            ex_next.done   = 1'b1;
            ex_next.result = dmemload;
            ex_next.rd     = ls_rd;
            ex_next.wen    = !ls_store;
        end else if (issue_in.valid && !is_ls) begin
            ex_next.done = 1'b1;
            ex_next.rd   = issue_in.rd;
            ex_next.halt = issue_in.halt;
            case (issue_in.fu_sel)
                datapath_pkg::FU_ALU: begin
                    ex_next.result = alu_result;
                    ex_next.wen    = 1'b1;
                end
                datapath_pkg::FU_BR: begin
                    // link value, only written for jal
                    ex_next.result = issue_in.pc + datapath_pkg::word_t'(4);
                    ex_next.wen    = issue_in.jal;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            ls_state <= LS_IDLE;
            ex_out   <= '0;
            redirect <= '0;
        end else begin
            ex_out        <= ex_next;
            redirect.miss <= issue_in.valid && (issue_in.fu_sel == datapath_pkg::FU_BR) &&
                             (issue_in.jal || taken);
            redirect.pc   <= issue_in.pc + issue_in.imm;
            case (ls_state)
                LS_IDLE: begin
                    if (is_ls) begin
                        ls_state <= LS_WAIT_HIT;
                    end
                end
                LS_WAIT_HIT: begin
                    if (dhit) begin
                        ls_state <= LS_IDLE;
                    end
                end
                default: ls_state <= LS_IDLE;
            endcase
        end
    end

    // capture the access at issue
    always_ff @(posedge CLK) begin
        if (is_ls) begin
            ls_addr  <= issue_in.rdat1 + issue_in.imm;
            ls_data  <= issue_in.rdat2;
            ls_rd    <= issue_in.rd;
            ls_store <= issue_in.store;
        end
    end

endmodule

// File: hdl/writeback.sv
// result writeback
module writeback (
    input  datapath_pkg::execute_t wb_latch_in,
    output datapath_pkg::wb_t      wb_out,
    output logic                   halt_seen
);
    logic do_write;

    // writes to x0 are dropped here
    assign do_write = wb_latch_in.done && wb_latch_in.wen && (wb_latch_in.rd != '0);

    always_comb begin
        wb_out      = '0;
        wb_out.wen  = do_write;
        wb_out.sel  = wb_latch_in.rd;
        wb_out.data = wb_latch_in.result;
    end

    // halt has drained to the end of the pipe
    assign halt_seen = wb_latch_in.done && wb_latch_in.halt;

endmodule

// File: hdl/sc_datapath.sv
// scalar pipeline top level
module sc_datapath (
    input  logic                CLK,
    input  logic                nrst,
    input  logic                ihit,
    input  datapath_pkg::word_t imemload,
    input  logic                dhit,
    input  datapath_pkg::word_t dmemload,
    output logic                imemREN,
    output datapath_pkg::word_t imemaddr,
    output logic                dmemREN,
    output logic                dmemWEN,
    output datapath_pkg::word_t dmemstore,
    output datapath_pkg::word_t dmemaddr,
    output logic                halt
);
    datapath_pkg::fetch_t fetch_out, sb_in;
    datapath_pkg::issue_t issue;
    datapath_pkg::execute_t ex_out, wb_latch;
    datapath_pkg::redirect_t redirect;
    datapath_pkg::wb_t wb;
    datapath_pkg::reg_sel_t rsel1, rsel2;
    datapath_pkg::word_t rdat1, rdat2;
    logic freeze, busy, halt_seen;

    fetch_stage fetch_inst (
        .CLK          (CLK),
        .nrst         (nrst),
        .ihit         (ihit),
        .imemload     (imemload),
        .freeze       (freeze),
        .redirect     (redirect),
        .halted_fetch (halt),
        .imemREN      (imemREN),
        .imemaddr     (imemaddr),
        .fetch_out    (fetch_out)
    );

    scoreboard scoreboard_inst (
        .CLK       (CLK),
        .nrst      (nrst),
        .fetch_in  (sb_in),
        .redirect  (redirect),
        .busy      (busy),
        .wb_in     (wb),
        .rdat1     (rdat1),
        .rdat2     (rdat2),
        .rsel1     (rsel1),
        .rsel2     (rsel2),
        .freeze    (freeze),
        .issue_out (issue)
    );

    regfile regfile_inst (
        .CLK   (CLK),
        .nrst  (nrst),
        .wb_in (wb),
        .rsel1 (rsel1),
        .rsel2 (rsel2),
        .rdat1 (rdat1),
        .rdat2 (rdat2)
    );

    execute execute_inst (
        .CLK       (CLK),
        .nrst      (nrst),
        .issue_in  (issue),
        .dhit      (dhit),
        .dmemload  (dmemload),
        .dmemREN   (dmemREN),
        .dmemWEN   (dmemWEN),
        .dmemstore (dmemstore),
        .dmemaddr  (dmemaddr),
        .busy      (busy),
        .ex_out    (ex_out),
        .redirect  (redirect)
    );

    writeback writeback_inst (
        .wb_latch_in (wb_latch),
        .wb_out      (wb),
        .halt_seen   (halt_seen)
    );

    // fetch and writeback latches, halt is sticky
    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            sb_in    <= '0;
            wb_latch <= '0;
            halt     <= 1'b0;
        end else begin
            wb_latch <= ex_out;
            halt     <= halt || halt_seen;
            if (redirect.miss) begin
                sb_in <= '0;
            end else if (!freeze) begin
                sb_in <= fetch_out;
            end
        end
    end

endmodule

// File: testbench/clock_gen.sv
// testbench clock and reset
module clock_gen #(
    parameter int period_ns    = 8,
    parameter int reset_cycles = 3
) (
    output logic CLK,
    output logic nrst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        CLK = 1'b0;
        forever begin
            #(period_ns / 2) CLK = ~CLK;
        end
    end

    // active low, released on a rising edge
    initial begin
        nrst = 1'b0;
        repeat (reset_cycles) @(posedge CLK);
        nrst <= 1'b1;
    end

endmodule

// File: testbench/tb_sc_datapath.sv
// scalar pipeline testbench
`include "datapath_macros.svh"

module tb_sc_datapath;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int prog_len         = 200;
    localparam int cycles_per_instr = 10;
    localparam int clk_period       = 8;
    localparam int reset_cycles     = 3;
    localparam int drain_cycles     = 20;
    localparam int timeout_cycles   = prog_len * cycles_per_instr + reset_cycles + drain_cycles;

    typedef enum logic [3:0] {
        K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLT,
        K_ADDI, K_LW, K_SW, K_BEQ, K_BNE, K_JAL, K_HALT
    } kind_t;

    typedef struct packed {
        kind_t                  kind;
        datapath_pkg::reg_sel_t rd, rs1, rs2;
        datapath_pkg::word_t    imm;
    } prog_op_t;

    typedef struct packed {
        datapath_pkg::word_t addr;
        datapath_pkg::word_t data;
    } store_t;

    logic CLK, nrst;
    logic ihit, dhit, imemREN, dmemREN, dmemWEN, halt;
    datapath_pkg::word_t imemload, dmemload, imemaddr, dmemaddr, dmemstore;

    integer seed = 32'h7034;
    prog_op_t prog [prog_len];
    datapath_pkg::word_t imem [256];
    datapath_pkg::word_t dmem [64];
    store_t exp_stores [$];
    int store_count = 0;

    // request side as seen at the falling edge
    logic imem_req_s, redirect_s, dmem_req_s, dmem_wr_s;
    datapath_pkg::word_t imem_addr_s, dmem_addr_s, dmem_data_s;
    int imem_wait, dmem_wait;

    clock_gen #(
        .period_ns    (clk_period),
        .reset_cycles (reset_cycles)
    ) clock_gen_inst (
        .CLK  (CLK),
        .nrst (nrst)
    );

    sc_datapath sc_datapath_inst (
        .CLK       (CLK),
        .nrst      (nrst),
        .ihit      (ihit),
        .imemload  (imemload),
        .dhit      (dhit),
        .dmemload  (dmemload),
        .imemREN   (imemREN),
        .imemaddr  (imemaddr),
        .dmemREN   (dmemREN),
        .dmemWEN   (dmemWEN),
        .dmemstore (dmemstore),
        .dmemaddr  (dmemaddr),
        .halt      (halt)
    );

    task automatic stop_with_error(input string reason);
        $display("%s", reason);
        $display("Done: errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input datapath_pkg::word_t expected,
                               input datapath_pkg::word_t actual);
        if (actual !== expected) begin
            stop_with_error($sformatf("mismatch %s: expected %h, actual %h",
                                      name, expected, actual));
        end
    endtask

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic datapath_pkg::reg_sel_t pick_reg();
        // few registers so hazards are frequent
        return datapath_pkg::reg_sel_t'(rand_below(8));
    endfunction

    function automatic datapath_pkg::word_t fill_word(input int idx);
        return 32'hc3a5_0000 ^ (datapath_pkg::word_t'(idx) * 32'h0001_0409);
    endfunction

    // rv32i encodings of the generated ops
    function automatic datapath_pkg::word_t encode(input prog_op_t op);
        datapath_pkg::word_t w;
        logic [2:0] f3;
        case (op.kind)
            K_AND:       f3 = 3'b111;
            K_OR:        f3 = 3'b110;
            K_XOR:       f3 = 3'b100;
            K_SLT:       f3 = 3'b010;
            K_LW, K_SW:  f3 = 3'b010;
            K_BNE:       f3 = 3'b001;
            default:     f3 = 3'b000;
        endcase
        case (op.kind)
            K_ADDI: w = {op.imm[11:0], op.rs1, f3, op.rd, 7'b0010011};
            K_LW:   w = {op.imm[11:0], op.rs1, f3, op.rd, 7'b0000011};
            K_SW:   w = {op.imm[11:5], op.rs2, op.rs1, f3, op.imm[4:0], 7'b0100011};
            K_BEQ, K_BNE: begin
                w = {op.imm[12], op.imm[10:5], op.rs2, op.rs1, f3, op.imm[4:1], op.imm[11],
                     7'b1100011};
            end
            K_JAL:  w = {op.imm[20], op.imm[10:1], op.imm[11], op.imm[19:12], op.rd, 7'b1101111};
            K_HALT: w = '1;
            default: begin
                w = {(op.kind == K_SUB) ? 7'b0100000 : 7'b0000000, op.rs2, op.rs1, f3, op.rd,
                     7'b0110011};
            end
        endcase
        return w;
    endfunction

    task automatic build_program();
        int r;
        int off;
        prog_op_t op;
        for (int i = 0; i < prog_len - 1; i++) begin
            op     = '0;
            op.rd  = pick_reg();
            op.rs1 = pick_reg();
            op.rs2 = pick_reg();
            // forward targets only, never past the final halt
            off = 1 + rand_below(6);
            if (i + off > prog_len - 1) begin
                off = prog_len - 1 - i;
            end
            r = rand_below(100);
            if (r < 30) begin
                op.kind = kind_t'(rand_below(6));
            end else if (r < 48) begin
                op.kind = K_ADDI;
                op.imm  = datapath_pkg::word_t'(rand_below(4096) - 2048);
            end else if (r < 80) begin
                op.kind = (r < 62) ? K_LW : K_SW;
                op.imm  = datapath_pkg::word_t'(rand_below(64) * 4);
            end else begin
                op.kind = (r < 92) ? (rand_below(2) ? K_BNE : K_BEQ) : K_JAL;
                op.imm  = datapath_pkg::word_t'(off * 4);
            end
            prog[i] = op;
        end
        prog[prog_len - 1]      = '0;
        prog[prog_len - 1].kind = K_HALT;
        foreach (imem[i]) imem[i] = '1;
        foreach (prog[i]) imem[i] = encode(prog[i]);
        foreach (dmem[i]) dmem[i] = fill_word(i);
    endtask

    // architectural model, fills the expected store queue
    task automatic run_model();
        datapath_pkg::word_t regs [`DP_REG_N];
        datapath_pkg::word_t mem [64];
        datapath_pkg::word_t pc, next_pc, a, b, res, addr;
        prog_op_t op;
        logic wr;
        store_t st;
        foreach (regs[i]) regs[i] = '0;
        foreach (mem[i]) mem[i] = fill_word(i);
        pc = `DP_RESET_PC;
        op = prog[pc >> 2];
        while (op.kind != K_HALT) begin
            a       = regs[op.rs1];
            b       = regs[op.rs2];
            addr    = a + op.imm;
            next_pc = pc + 4;
            wr      = 1'b1;
            res     = '0;
            case (op.kind)
                K_ADD:  res = a + b;
                K_SUB:  res = a - b;
                K_AND:  res = a & b;
                K_OR:   res = a | b;
                K_XOR:  res = a ^ b;
                K_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                K_ADDI: res = a + op.imm;
                K_LW:   res = mem[addr[7:2]];
                K_SW: begin
                    wr      = 1'b0;
                    st.addr = addr;
                    st.data = b;
                    exp_stores.push_back(st);
                    mem[addr[7:2]] = b;
                end
                K_BEQ, K_BNE: begin
                    wr = 1'b0;
                    if ((a == b) == (op.kind == K_BEQ)) begin
                        next_pc = pc + op.imm;
                    end
                end
                K_JAL: begin
                    res     = pc + 4;
                    next_pc = pc + op.imm;
                end
                default: wr = 1'b0;
            endcase
            if (wr && (op.rd != 0)) begin
                regs[op.rd] = res;
            end
            pc = next_pc;
            op = prog[pc >> 2];
        end
    endtask

    task automatic compare_store(input datapath_pkg::word_t addr,
                                 input datapath_pkg::word_t data);
        store_t st;
        if (exp_stores.size() == 0) begin
            stop_with_error($sformatf("store to address %h that the model never made", addr));
        end else begin
            st = exp_stores.pop_front();
            store_count++;
            check_value($sformatf("store %0d address", store_count), st.addr, addr);
            check_value($sformatf("store %0d data", store_count), st.data, data);
        end
    endtask

    always @(negedge CLK) begin
        imem_req_s  = imemREN;
        imem_addr_s = imemaddr;
        // fetch jumps to the target at the next edge, so any answer now is stale
        redirect_s  = sc_datapath_inst.redirect.miss;
        dmem_req_s  = dmemREN || dmemWEN;
        dmem_wr_s   = dmemWEN;
        dmem_addr_s = dmemaddr;
        dmem_data_s = dmemstore;
    end

    // instruction and data memories, one edge behind the sampled request
    always @(posedge CLK) begin
        if (!nrst) begin
            ihit      <= 1'b0;
            dhit      <= 1'b0;
            imem_wait = -1;
            dmem_wait = -1;
        end else begin
            ihit <= 1'b0;
            if (ihit || redirect_s || !imem_req_s) begin
                imem_wait = -1;
            end else begin
                if (imem_wait < 0) begin
                    imem_wait = rand_below(3);
                end
                if (imem_wait == 0) begin
                    ihit     <= 1'b1;
                    imemload <= imem[imem_addr_s[9:2]];
                end
                imem_wait = imem_wait - 1;
            end
            dhit <= 1'b0;
            if (dhit || !dmem_req_s) begin
                dmem_wait = -1;
            end else begin
                if (dmem_wait < 0) begin
                    dmem_wait = rand_below(4);
                end
                if (dmem_wait == 0) begin
                    dhit <= 1'b1;
                    if (dmem_wr_s) begin
                        compare_store(dmem_addr_s, dmem_data_s);
                        dmem[dmem_addr_s[7:2]] = dmem_data_s;
                    end else begin
                        dmemload <= dmem[dmem_addr_s[7:2]];
                    end
                end
                dmem_wait = dmem_wait - 1;
            end
        end
    end

    initial begin : watchdog
        #(timeout_cycles * clk_period);
        stop_with_error($sformatf("timeout: halt did not rise within %0d cycles",
                                  timeout_cycles));
    end

    initial begin
        ihit     = 1'b0;
        imemload = '0;
        dhit     = 1'b0;
        dmemload = '0;
        build_program();
        run_model();
        $display("program built, model expects %0d stores", exp_stores.size());
        repeat (reset_cycles) begin
            @(negedge CLK);
            check_value("reset dmemREN", 0, dmemREN);
            check_value("reset dmemWEN", 0, dmemWEN);
            check_value("reset halt", 0, halt);
            check_value("reset imemaddr", `DP_RESET_PC, imemaddr);
        end
        while (halt !== 1'b1) begin
            @(negedge CLK);
        end
        // pipe must stay quiet once halted
        repeat (drain_cycles) begin
            @(negedge CLK);
            check_value("halt held", 1, halt);
            check_value("imemREN after halt", 0, imemREN);
            check_value("dmemWEN after halt", 0, dmemWEN);
        end
        check_value("stores left in model queue", 0, exp_stores.size());
        $display("Done: no errors");
        $finish;
    end

endmodule

// File: src.f
+incdir+include
hdl/datapath_pkg.sv
hdl/fetch_stage.sv
hdl/scoreboard.sv
hdl/regfile.sv
hdl/execute.sv
hdl/writeback.sv
hdl/sc_datapath.sv
testbench/clock_gen.sv
testbench/tb_sc_datapath.sv

// File: Bender.yml
package:
  name: sc_datapath

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/datapath_pkg.sv
      - hdl/fetch_stage.sv
      - hdl/scoreboard.sv
      - hdl/regfile.sv
      - hdl/execute.sv
      - hdl/writeback.sv
      - hdl/sc_datapath.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - testbench/clock_gen.sv
      - testbench/tb_sc_datapath.sv
